// File: Makefile
# Verilator build and run for the single-cycle MIPS core testbench
# any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Test completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/mips_alu.sv
// integer ALU for the core, also flags operand equality for beq/bne
// combinational, shifts take rt on op_b and the amount from shamt
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_alu
   import mips_pkg::*;
(
   input  logic [`MIPS_XLEN-1:0] op_a,
   input  logic [`MIPS_XLEN-1:0] op_b,
   input  logic [4:0]            shamt,
   input  alu_op_e               alu_op,
   output logic [`MIPS_XLEN-1:0] result,
   output logic                  equal
);

   // branch compare, op_b is rt for branches
   assign equal = (op_a == op_b);

   always_comb
   begin
      case (alu_op)
         // add and sub wrap, no overflow trap
         ALU_ADD:
            result = op_a + op_b;
         ALU_SUB:
            result = op_a - op_b;
         ALU_AND:
            result = op_a & op_b;
         ALU_OR:
            result = op_a | op_b;
         ALU_XOR:
            result = op_a ^ op_b;
         ALU_NOR:
            result = ~(op_a | op_b);
         // signed compare, 1 or 0
         ALU_SLT:
            result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         ALU_SLL:
            result = op_b << shamt;
         ALU_SRL:
            result = op_b >> shamt;
         // sign bit fills from the left
         ALU_SRA:
            result = $signed(op_b) >>> shamt;
         // immediate arrives zero extended, move it to the upper half
         ALU_LUI:
            result = {op_b[15:0], 16'h0000};
         default:
            result = op_a + op_b;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/mips_consts.svh
// widths, register count and reset PC of the single-cycle MIPS core
// included by every RTL file and by the testbench
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// data path and register width
`define MIPS_XLEN 32

// word address width, same on instruction and data ports
`define MIPS_WADDR 30

// architectural register count
`define MIPS_NREGS 32

// bits needed to index one register
`define MIPS_RIDX 5

// PC value after reset, start of the text segment
`define MIPS_TEXT_START 32'h00400000

// jal writes its link address here
`define MIPS_REG_RA 5'd31

`endif

// File: hdl/mips_core.sv
// single-cycle MIPS core top level, one instruction retires per clock
// memories sit outside and answer combinationally on word addresses
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_core
   import mips_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic [31:0]            inst,
   input  logic [31:0]            mem_rdata,
   output logic [`MIPS_WADDR-1:0] inst_addr,
   output logic [`MIPS_WADDR-1:0] mem_addr,
   output logic [31:0]            mem_wdata,
   output logic                   mem_we,
   output logic                   halted
);

   // decoded fields and controls
   logic [`MIPS_RIDX-1:0] rs_idx;
   logic [`MIPS_RIDX-1:0] rt_idx;
   logic [`MIPS_RIDX-1:0] wr_idx;
   logic [`MIPS_XLEN-1:0] imm_ext;
   logic [4:0]            shamt;
   logic [25:0]           jump_field;
   alu_op_e               alu_op;
   logic                  alu_src_imm;
   logic                  reg_we;
   logic                  mem_we_raw;
   logic                  branch_ne;
   logic                  halt_req;
   pc_sel_e               pc_sel;
   wb_sel_e               wb_sel;

   // datapath
   logic [`MIPS_XLEN-1:0] rs_data;
   logic [`MIPS_XLEN-1:0] rt_data;
   logic [`MIPS_XLEN-1:0] op_b;
   logic [`MIPS_XLEN-1:0] alu_result;
   logic                  equal;
   logic [`MIPS_XLEN-1:0] link_addr;
   logic [`MIPS_XLEN-1:0] wr_data;
   logic                  reg_wr_en;

   mips_decode u_decode (
      .inst        (inst),
      .rs_idx      (rs_idx),
      .rt_idx      (rt_idx),
      .wr_idx      (wr_idx),
      .imm_ext     (imm_ext),
      .shamt       (shamt),
      .jump_field  (jump_field),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .reg_we      (reg_we),
      .mem_we_raw  (mem_we_raw),
      .branch_ne   (branch_ne),
      .halt_req    (halt_req),
      .pc_sel      (pc_sel),
      .wb_sel      (wb_sel)
   );

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .wr_en   (reg_wr_en),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   // second operand is rt for R-type and branches, immediate otherwise
   assign op_b = alu_src_imm ? imm_ext : rt_data;

   mips_alu u_alu (
      .op_a   (rs_data),
      .op_b   (op_b),
      .shamt  (shamt),
      .alu_op (alu_op),
      .result (alu_result),
      .equal  (equal)
   );

   mips_pc_unit u_pc (
      .clk        (clk),
      .rst_b      (rst_b),
      .pc_sel     (pc_sel),
      .equal      (equal),
      .branch_ne  (branch_ne),
      .halt_req   (halt_req),
      .imm_ext    (imm_ext),
      .jump_field (jump_field),
      .rs_data    (rs_data),
      .inst_addr  (inst_addr),
      .link_addr  (link_addr),
      .halted     (halted)
   );

   // writeback source
   always_comb
   begin
      case (wb_sel)
         WB_MEM:  wr_data = mem_rdata;
         WB_LINK: wr_data = link_addr;
         default: wr_data = alu_result;
      endcase
   end

   // nothing is written once the core has stopped
   assign reg_wr_en = reg_we & ~halted;

   // data port, word address from the ALU sum
   assign mem_addr  = alu_result[31:2];
   assign mem_wdata = rt_data;
   // store must not fire while reset holds the core either
   assign mem_we    = mem_we_raw & ~halted & rst_b;

endmodule

`default_nettype wire

// File: hdl/mips_decode.sv
// instruction decoder: splits the word into fields and builds the control set
// purely combinational, one instance inside mips_core
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_decode
   import mips_pkg::*;
(
   input  logic [31:0]             inst,
   output logic [`MIPS_RIDX-1:0]   rs_idx,
   output logic [`MIPS_RIDX-1:0]   rt_idx,
   output logic [`MIPS_RIDX-1:0]   wr_idx,
   output logic [`MIPS_XLEN-1:0]   imm_ext,
   output logic [4:0]              shamt,
   output logic [25:0]             jump_field,
   output alu_op_e                 alu_op,
   output logic                    alu_src_imm,
   output logic                    reg_we,
   output logic                    mem_we_raw,
   output logic                    branch_ne,
   output logic                    halt_req,
   output pc_sel_e                 pc_sel,
   output wb_sel_e                 wb_sel
);

   opcode_e op;
   funct_e  funct;
   // immediate is zero extended for the logical ops and lui
   logic    zero_ext;
   // jal forces the link register as destination
   logic    link;
   // R-type writes rd, everything else writes rt
   logic    rd_dst;

   assign op         = opcode_e'(inst[31:26]);
   assign funct      = funct_e'(inst[5:0]);
   assign rs_idx     = inst[25:21];
   assign rt_idx     = inst[20:16];
   assign shamt      = inst[10:6];
   assign jump_field = inst[25:0];

   assign imm_ext = zero_ext ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

   assign wr_idx = link ? `MIPS_REG_RA : (rd_dst ? inst[15:11] : inst[20:16]);

   always_comb
   begin
      // defaults describe a harmless no-op
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b0;
      pc_sel      = PC_SEQ;
      wb_sel      = WB_ALU;
      reg_we      = 1'b0;
      mem_we_raw  = 1'b0;
      branch_ne   = 1'b0;
      halt_req    = 1'b0;
      zero_ext    = 1'b0;
      link        = 1'b0;
      rd_dst      = 1'b0;
      case (op)
         OP_RTYPE:
         begin
            rd_dst = 1'b1;
            reg_we = 1'b1;
            case (funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_JR:
               begin
                  reg_we = 1'b0;
                  pc_sel = PC_REG;
               end
               // syscall and unknown funct codes both stop the core
               default:
               begin
                  reg_we   = 1'b0;
                  halt_req = 1'b1;
               end
            endcase
         end
         OP_ADDIU:
         begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_SLTI:
         begin
            alu_op      = ALU_SLT;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI:
         begin
            alu_op      = (op == OP_ANDI) ? ALU_AND : ((op == OP_ORI) ? ALU_OR : ALU_XOR);
            alu_src_imm = 1'b1;
            zero_ext    = 1'b1;
            reg_we      = 1'b1;
         end
         OP_LUI:
         begin
            alu_op      = ALU_LUI;
            alu_src_imm = 1'b1;
            zero_ext    = 1'b1;
            reg_we      = 1'b1;
         end
         OP_LW:
         begin
            alu_src_imm = 1'b1;
            wb_sel      = WB_MEM;
            reg_we      = 1'b1;
         end
         OP_SW:
         begin
            alu_src_imm = 1'b1;
            mem_we_raw  = 1'b1;
         end
         // both branches compare rs with rt, taken decision lives in the PC unit
         OP_BEQ:
            pc_sel = PC_BRANCH;
         OP_BNE:
         begin
            pc_sel    = PC_BRANCH;
            branch_ne = 1'b1;
         end
         OP_J:
            pc_sel = PC_JUMP;
         OP_JAL:
         begin
            pc_sel = PC_JUMP;
            wb_sel = WB_LINK;
            link   = 1'b1;
            reg_we = 1'b1;
         end
         // reserved instruction
         default:
            halt_req = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/mips_pc_unit.sv
// program counter with next-PC selection and the halted flag
// pc and halted update on the rising edge, targets are combinational
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_pc_unit
   import mips_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_b,
   input  pc_sel_e                pc_sel,
   input  logic                   equal,
   input  logic                   branch_ne,
   input  logic                   halt_req,
   input  logic [`MIPS_XLEN-1:0]  imm_ext,
   input  logic [25:0]            jump_field,
   input  logic [`MIPS_XLEN-1:0]  rs_data,
   output logic [`MIPS_WADDR-1:0] inst_addr,
   output logic [`MIPS_XLEN-1:0]  link_addr,
   output logic                   halted
);

   logic [`MIPS_XLEN-1:0] pc;
   logic [`MIPS_XLEN-1:0] pc_plus4;
   logic [`MIPS_XLEN-1:0] br_target;
   logic [`MIPS_XLEN-1:0] j_target;
   logic [`MIPS_XLEN-1:0] next_pc;
   logic                  taken;

   assign pc_plus4  = pc + 32'd4;
   assign link_addr = pc + 32'd8;
   // word offset relative to the following instruction
   assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
   // region bits come from pc plus 4
   assign j_target  = {pc_plus4[31:28], jump_field, 2'b00};
   // beq wants equal, bne wants not equal
   assign taken     = equal ^ branch_ne;

   always_comb
   begin
      case (pc_sel)
         PC_BRANCH: next_pc = taken ? br_target : pc_plus4;
         PC_JUMP:   next_pc = j_target;
         PC_REG:    next_pc = rs_data;
         default:   next_pc = pc_plus4;
      endcase
   end

   // a halting instruction sets halted and leaves pc on itself
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end
      else if (!halted)
      begin
         if (halt_req)
            halted <= 1'b1;
         else
            pc <= next_pc;
      end
   end

   assign inst_addr = pc[31:2];

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
// enum types shared by the decoder, ALU, PC unit and core top level
// modules import this package by wildcard in their header
`default_nettype none

package mips_pkg;

   // primary opcodes known to the decoder, anything else halts the core
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0a,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_e;

   // funct field of R-type instructions
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   // ALU function select
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   // next PC source
   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JUMP,
      PC_REG
   } pc_sel_e;

   // register writeback source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_LINK
   } wb_sel_e;

endpackage

`default_nettype wire

// File: hdl/mips_regfile.sv
// general purpose register file, two combinational reads and one write port
// register zero reads as zero and ignores writes
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_regfile
(
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic [`MIPS_RIDX-1:0] rs_idx,
   input  logic [`MIPS_RIDX-1:0] rt_idx,
   input  logic [`MIPS_RIDX-1:0] wr_idx,
   input  logic [`MIPS_XLEN-1:0] wr_data,
   input  logic                  wr_en,
   output logic [`MIPS_XLEN-1:0] rs_data,
   output logic [`MIPS_XLEN-1:0] rt_data
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

   // reset clears the whole file
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < `MIPS_NREGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en && (wr_idx != '0))
      begin
         regs[wr_idx] <= wr_data;
      end
   end

   // reads see the old value during the writing cycle
   assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
   assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

// File: mips_core.f
+incdir+hdl
+incdir+tests
hdl/mips_pkg.sv
hdl/mips_decode.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_pc_unit.sv
hdl/mips_core.sv
tests/mips_core_tb.sv

// File: tests/mips_tb_tasks.svh
// encoders, reference model and directed tests for the MIPS core testbench
// included inside mips_core_tb and uses its memories, counters and DUT signals
`ifndef MIPS_TB_TASKS_SVH
`define MIPS_TB_TASKS_SVH

// MIPS opcode and funct encodings
localparam logic [5:0] OP_J     = 6'h02;
localparam logic [5:0] OP_JAL   = 6'h03;
localparam logic [5:0] OP_BEQ   = 6'h04;
localparam logic [5:0] OP_BNE   = 6'h05;
localparam logic [5:0] OP_ADDIU = 6'h09;
localparam logic [5:0] OP_SLTI  = 6'h0a;
localparam logic [5:0] OP_ANDI  = 6'h0c;
localparam logic [5:0] OP_ORI   = 6'h0d;
localparam logic [5:0] OP_XORI  = 6'h0e;
localparam logic [5:0] OP_LUI   = 6'h0f;
localparam logic [5:0] OP_LW    = 6'h23;
localparam logic [5:0] OP_SW    = 6'h2b;
localparam logic [5:0] F_SLL    = 6'h00;
localparam logic [5:0] F_SRL    = 6'h02;
localparam logic [5:0] F_SRA    = 6'h03;
localparam logic [5:0] F_JR     = 6'h08;
localparam logic [5:0] F_SYSC   = 6'h0c;
localparam logic [5:0] F_ADDU   = 6'h21;
localparam logic [5:0] F_SUBU   = 6'h23;
localparam logic [5:0] F_AND    = 6'h24;
localparam logic [5:0] F_OR     = 6'h25;
localparam logic [5:0] F_XOR    = 6'h26;
localparam logic [5:0] F_NOR    = 6'h27;
localparam logic [5:0] F_SLT    = 6'h2a;
localparam logic [29:0] TEXT_WORD = 30'(`MIPS_TEXT_START >> 2);

// compares a DUT value with its expected value
task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
   end
endtask

// untouched data word tied to its index
function automatic logic [31:0] fill_word(input int idx);
   return {16'hd0d0, 16'(idx)};
endfunction

function automatic logic [31:0] sext16(input logic [15:0] imm);
   return {{16{imm[15]}}, imm};
endfunction

// two's complement order
// differing signs decide alone, equal signs compare like unsigned
function automatic logic signed_lt(input logic [31:0] a, input logic [31:0] b);
   if (a[31] != b[31])
      return a[31];
   return a < b;
endfunction

function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd,
                                       input logic [4:0] sh);
   return {6'h00, rs, rt, rd, sh, funct};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// jump to program word idx of the text segment
function automatic logic [31:0] j_type(input logic [5:0] op, input int idx);
   logic [31:0] addr;
   addr = `MIPS_TEXT_START + 32'(4 * idx);
   return {op, addr[27:2]};
endfunction

// expected result of an R-type operation
function automatic logic [31:0] alu_ref(input logic [5:0] funct, input logic [31:0] a,
                                        input logic [31:0] b, input logic [4:0] sh);
   case (funct)
      F_ADDU: return a + b;
      F_SUBU: return a - b;
      F_AND:  return a & b;
      F_OR:   return a | b;
      F_XOR:  return a ^ b;
      F_NOR:  return ~(a | b);
      F_SLT:  return {31'd0, signed_lt(a, b)};
      F_SLL:  return b << sh;
      F_SRL:  return b >> sh;
      // logical shift with the vacated top bits copied from the sign
      F_SRA:  return (b >> sh) | ({32{b[31]}} & ~(32'hffff_ffff >> sh));
      default: return 32'hxxxx_xxxx;
   endcase
endfunction

task automatic emit(input logic [31:0] word);
   imem[prog_len] = word;
   prog_len++;
endtask

// lui/ori pair puts a full word in a register
task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
   emit(i_type(OP_LUI, 5'd0, rd, value[31:16]));
   emit(i_type(OP_ORI, rd, rd, value[15:0]));
endtask

// sw rt to a data word slot with base register zero
task automatic store_word(input logic [4:0] rt, input int slot);
   emit(i_type(OP_SW, 5'd0, rt, 16'(slot * 4)));
endtask

// holds the core in reset and clears both memories
task automatic begin_program();
   @(posedge clk);
   rst_b    <= 1'b0;
   fill_req <= 1'b1;
   // unused program words hold a reserved opcode so a runaway pc halts
   for (int i = 0; i < 256; i++)
   begin
      imem[i] = {6'h3f, 26'(i)};
   end
   prog_len = 0;
   @(posedge clk);
   fill_req <= 1'b0;
endtask

// finishes the 16 reset cycles and waits for halted
task automatic run_program();
   // core sits at the reset vector and must not store while held
   repeat (15)
   begin
      @(negedge clk);
      check_equal("reset pc", {2'b00, inst_addr}, {2'b00, TEXT_WORD});
      check_equal("halted in reset", {31'd0, halted}, 32'd0);
      check_equal("store in reset", {31'd0, mem_we}, 32'd0);
      @(posedge clk);
   end
   rst_b <= 1'b1;
   @(negedge clk);
   while (!halted)
   begin
      @(negedge clk);
   end
endtask

task automatic alu_reg_ops();
   logic [31:0] a;
   logic [31:0] b;
   logic [5:0] fn [7];
   fn = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT};
   a = $urandom;
   b = $urandom;
   begin_program();
   load_const(5'd8, a);
   load_const(5'd9, b);
   for (int k = 0; k < 7; k++)
   begin
      emit(r_type(fn[k], 5'd8, 5'd9, 5'd10, 5'd0));
      store_word(5'd10, k);
   end
   // slt with the operands swapped covers the other outcome
   emit(r_type(F_SLT, 5'd9, 5'd8, 5'd10, 5'd0));
   store_word(5'd10, 7);
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   run_program();
   for (int k = 0; k < 7; k++)
   begin
      check_equal($sformatf("alu funct %h", fn[k]), dmem[k], alu_ref(fn[k], a, b, 5'd0));
   end
   check_equal("slt swapped", dmem[7], alu_ref(F_SLT, b, a, 5'd0));
endtask

task automatic imm_and_shift_ops();
   logic [31:0] a;
   // sign bit set so sra and srl differ
   a = $urandom | 32'h8000_0000;
   begin_program();
   load_const(5'd8, a);
   emit(i_type(OP_ADDIU, 5'd8, 5'd10, 16'hff80));
   store_word(5'd10, 0);
   emit(i_type(OP_ANDI, 5'd8, 5'd10, 16'hf0f0));
   store_word(5'd10, 1);
   emit(i_type(OP_ORI, 5'd8, 5'd10, 16'h8001));
   store_word(5'd10, 2);
   emit(i_type(OP_XORI, 5'd8, 5'd10, 16'hffff));
   store_word(5'd10, 3);
   emit(i_type(OP_SLTI, 5'd8, 5'd10, 16'hfff0));
   store_word(5'd10, 4);
   emit(i_type(OP_LUI, 5'd0, 5'd10, 16'h8a5c));
   store_word(5'd10, 5);
   emit(r_type(F_SLL, 5'd0, 5'd8, 5'd10, 5'd7));
   store_word(5'd10, 6);
   emit(r_type(F_SRL, 5'd0, 5'd8, 5'd10, 5'd13));
   store_word(5'd10, 7);
   emit(r_type(F_SRA, 5'd0, 5'd8, 5'd10, 5'd13));
   store_word(5'd10, 8);
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   run_program();
   check_equal("addiu negative", dmem[0], a + sext16(16'hff80));
   check_equal("andi", dmem[1], a & {16'h0000, 16'hf0f0});
   check_equal("ori", dmem[2], a | {16'h0000, 16'h8001});
   check_equal("xori", dmem[3], a ^ {16'h0000, 16'hffff});
   check_equal("slti", dmem[4], {31'd0, signed_lt(a, sext16(16'hfff0))});
   check_equal("lui", dmem[5], 32'h8a5c_0000);
   check_equal("sll", dmem[6], alu_ref(F_SLL, 32'd0, a, 5'd7));
   check_equal("srl", dmem[7], alu_ref(F_SRL, 32'd0, a, 5'd13));
   check_equal("sra", dmem[8], alu_ref(F_SRA, 32'd0, a, 5'd13));
endtask

task automatic load_store_words();
   logic [31:0] x;
   logic [31:0] y;
   x = $urandom;
   y = $urandom;
   begin_program();
   load_const(5'd8, x);
   load_const(5'd9, y);
   store_word(5'd8, 16);
   store_word(5'd9, 17);
   emit(i_type(OP_LW, 5'd0, 5'd10, 16'h0040));
   emit(i_type(OP_LW, 5'd0, 5'd11, 16'h0044));
   emit(r_type(F_ADDU, 5'd10, 5'd11, 5'd12, 5'd0));
   store_word(5'd12, 18);
   // base register with positive and negative offsets
   emit(i_type(OP_ADDIU, 5'd0, 5'd13, 16'h0100));
   emit(i_type(OP_SW, 5'd13, 5'd8, 16'h0008));
   emit(i_type(OP_LW, 5'd13, 5'd14, 16'hfffc));
   store_word(5'd14, 19);
   // register zero must stay zero
   emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
   store_word(5'd0, 20);
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   run_program();
   check_equal("sw x", dmem[16], x);
   check_equal("sw y", dmem[17], y);
   check_equal("lw sum", dmem[18], x + y);
   check_equal("sw base+8", dmem[66], x);
   check_equal("lw base-4", dmem[19], fill_word(63));
   check_equal("store of r0", dmem[20], 32'd0);
endtask

task automatic branch_paths();
   logic [31:0] v;
   logic [5:0] op;
   logic [31:0] rt_val;
   logic taken;
   v = $urandom;
   begin_program();
   load_const(5'd8, v);
   load_const(5'd9, v);
   emit(i_type(OP_ADDIU, 5'd8, 5'd10, 16'h0001));
   // r20 marks the fall-through path and r21 the landing point
   emit(i_type(OP_ADDIU, 5'd0, 5'd20, 16'h5a5a));
   emit(i_type(OP_ADDIU, 5'd0, 5'd21, 16'h7e7e));
   for (int k = 0; k < 4; k++)
   begin
      op = (k < 2) ? OP_BEQ : OP_BNE;
      emit(i_type(op, 5'd8, (k == 0 || k == 3) ? 5'd9 : 5'd10, 16'h0001));
      store_word(5'd20, 2 * k);
      store_word(5'd21, 2 * k + 1);
   end
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   run_program();
   for (int k = 0; k < 4; k++)
   begin
      rt_val = (k == 0 || k == 3) ? v : v + 32'd1;
      taken = (k < 2) ? (v == rt_val) : (v != rt_val);
      check_equal($sformatf("branch %0d skipped slot", k), dmem[2 * k],
                  taken ? fill_word(2 * k) : 32'h0000_5a5a);
      check_equal($sformatf("branch %0d landing slot", k), dmem[2 * k + 1], 32'h0000_7e7e);
   end
endtask

task automatic jump_and_link();
   begin_program();
   emit(i_type(OP_ADDIU, 5'd0, 5'd20, 16'h3c3c));
   // word 1 calls the routine at word 8, which returns to word 3
   emit(j_type(OP_JAL, 8));
   emit(32'h0000_0000);
   emit(j_type(OP_J, 6));
   store_word(5'd20, 1);
   emit(32'h0000_0000);
   store_word(5'd20, 2);
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   store_word(5'd31, 3);
   emit(r_type(F_JR, 5'd31, 5'd0, 5'd0, 5'd0));
   run_program();
   check_equal("jal link", dmem[3], `MIPS_TEXT_START + 32'd4 + 32'd8);
   check_equal("j skipped store", dmem[1], fill_word(1));
   check_equal("j target store", dmem[2], 32'h0000_3c3c);
   check_equal("halt address", {2'b00, inst_addr}, {2'b00, TEXT_WORD + 30'd7});
endtask

task automatic halt_freeze();
   logic [`MIPS_WADDR-1:0] held;
   begin_program();
   // a store at the reset vector has to wait for reset release
   store_word(5'd0, 3);
   emit(i_type(OP_ADDIU, 5'd0, 5'd20, 16'h1357));
   emit(r_type(F_SYSC, 5'd0, 5'd0, 5'd0, 5'd0));
   store_word(5'd20, 0);
   run_program();
   held = inst_addr;
   check_equal("syscall address", {2'b00, held}, {2'b00, TEXT_WORD + 30'd2});
   // core must stay frozen
   repeat (20)
   begin
      @(negedge clk);
      check_equal("halted held", {31'd0, halted}, 32'd1);
      check_equal("pc frozen", {2'b00, inst_addr}, {2'b00, held});
      check_equal("no store", {31'd0, mem_we}, 32'd0);
   end
   check_equal("store at reset vector", dmem[3], 32'd0);
   check_equal("store after syscall", dmem[0], fill_word(0));
   // reserved opcode halts too
   begin_program();
   emit(i_type(OP_ADDIU, 5'd0, 5'd20, 16'h1357));
   store_word(5'd20, 1);
   emit(32'hfc00_0000);
   store_word(5'd20, 2);
   run_program();
   check_equal("reserved address", {2'b00, inst_addr}, {2'b00, TEXT_WORD + 30'd2});
   check_equal("store before reserved", dmem[1], 32'h0000_1357);
   check_equal("store after reserved", dmem[2], fill_word(2));
endtask

`endif

// File: tests/mips_core_tb.sv
// testbench top for the single-cycle MIPS core
// models both memories, drives reset and runs the directed tests in order
`timescale 1ns/100ps
`default_nettype none

`include "mips_consts.svh"

module mips_core_tb;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS  = 6;
   // cycle budget per test before the watchdog fires
   localparam int TEST_CYCLES = 2000;
   localparam logic [31:0] SEED = 32'h32c7;

   logic clk = 1'b0;
   logic rst_b;
   logic [31:0] inst;
   logic [31:0] mem_rdata;
   logic [`MIPS_WADDR-1:0] inst_addr;
   logic [`MIPS_WADDR-1:0] mem_addr;
   logic [31:0] mem_wdata;
   logic mem_we;
   logic halted;

   // 256 words of program starting at the text segment
   logic [31:0] imem [256];
   // 256 words of data from byte address zero
   logic [31:0] dmem [256];
   // word offset of the fetch from the start of the text segment
   logic [`MIPS_WADDR-1:0] imem_off;
   // refills data memory on the next edge
   logic fill_req;
   int prog_len = 0;
   int errors = 0;
   int checks = 0;

   `include "mips_tb_tasks.svh"

   always #(CLK_PERIOD / 2) clk = ~clk;

   mips_core uut (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst      (inst),
      .mem_rdata (mem_rdata),
      .inst_addr (inst_addr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   // fetches outside the loaded window return a reserved opcode
   assign imem_off = inst_addr - TEXT_WORD;
   assign inst = (imem_off < 30'd256) ? imem[imem_off[7:0]] : 32'hfc00_0000;

   // data memory reads combinationally and writes on the rising edge
   assign mem_rdata = dmem[mem_addr[7:0]];

   always @(posedge clk)
   begin
      if (fill_req)
      begin
         for (int i = 0; i < 256; i++)
         begin
            dmem[i] <= fill_word(i);
         end
      end
      else if (mem_we)
      begin
         dmem[mem_addr[7:0]] <= mem_wdata;
      end
   end

   // watchdog gives every test its cycle budget to halt
   initial
   begin
      #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("error: timeout after %0d cycles, the core never halted",
               NUM_TESTS * TEST_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      rst_b    <= 1'b0;
      fill_req <= 1'b0;
      void'($urandom(SEED));
      alu_reg_ops();
      imm_and_shift_ops();
      load_store_words();
      branch_paths();
      jump_and_link();
      halt_freeze();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
